// File: logic/riscvPkg.sv
// ISA level definitions for the RV32I integer subset
// Imported by every stage that touches instruction fields or data
package riscvPkg;

	// Datapath and register index widths
	localparam int XLEN  = 32;
	localparam int REG_W = 5;

	// Register count follows from the index width
	localparam int NREGS = 1 << REG_W;

	// Immediate field positions in the instruction word
	localparam int IMM_I_LSB = 20;
	localparam int IMM_U_LSB = 12;

	// Major opcodes handled by this core
	// Anything else decodes as illegal
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111
	} opcodeE;

	// ALU operations
	// PASS_B feeds operand B straight through, used by LUI
	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		SLTU,
		SLL,
		SRL,
		SRA,
		PASS_B
	} aluOpE;

	// funct3 codes shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

endpackage

// File: logic/pipePkg.sv
// Pipeline level definitions: stage registers and forwarding control
// ISA types come in by scoped reference to riscvPkg
package pipePkg;

	// Operand source chosen by the forwarding unit
	typedef enum logic [1:0] {
		NOFWD,   // Value read from the register file in decode
		FWD_MEM, // Result sitting in the execute/memory register
		FWD_WB   // Result sitting in the memory/writeback register
	} fwdSelE;

	// ALU source selects, low means immediate or zero
	typedef struct packed {
		logic aFromReg;
		logic bFromReg;
	} srcSelT;

	// Decode/execute register
	typedef struct packed {
		logic                             valid;
		logic                             illegal;
		riscvPkg::aluOpE                  aluOp;
		srcSelT                           srcSel;
		logic [riscvPkg::REG_W-1:0]       rs1;
		logic [riscvPkg::REG_W-1:0]       rs2;
		logic [riscvPkg::REG_W-1:0]       rd;
		logic                             regWrite;
		logic [riscvPkg::XLEN-1:0]        rs1Data;
		logic [riscvPkg::XLEN-1:0]        rs2Data;
		logic [riscvPkg::XLEN-1:0]        imm;
	} idExT;

	// Execute/memory register
	typedef struct packed {
		logic                       valid;
		logic                       illegal;
		logic [riscvPkg::REG_W-1:0] rd;
		logic                       regWrite;
		logic [riscvPkg::XLEN-1:0]  result;
	} exMemT;

	// Memory/writeback register, same layout one stage later
	typedef struct packed {
		logic                       valid;
		logic                       illegal;
		logic [riscvPkg::REG_W-1:0] rd;
		logic                       regWrite;
		logic [riscvPkg::XLEN-1:0]  result;
	} memWbT;

	// Forwarding unit inputs
	typedef struct packed {
		logic [riscvPkg::REG_W-1:0] exRs1;
		logic [riscvPkg::REG_W-1:0] exRs2;
		srcSelT                     srcSel;
		logic [riscvPkg::REG_W-1:0] memRd;
		logic                       memRegWrite;
		logic [riscvPkg::REG_W-1:0] wbRd;
		logic                       wbRegWrite;
	} fwdCtrlT;

	// Forwarding unit outputs, one select per operand
	typedef struct packed {
		fwdSelE fwdA;
		fwdSelE fwdB;
	} fwdMuxT;

	// Retire port payload
	typedef struct packed {
		logic [riscvPkg::REG_W-1:0] rd;
		logic [riscvPkg::XLEN-1:0]  data;
		logic                       regWrite;
		logic                       illegal;
	} retireT;

endpackage

// File: logic/regFile.sv
// Integer register file, two asynchronous read ports and one write port
// Reads see a same-cycle write, so retire and decode can overlap
`timescale 1ns/1ps

module regFile import riscvPkg::*; (
	input  logic             clk_i,
	input  logic             rstN_i,
	input  logic [REG_W-1:0] rs1Addr_i,
	input  logic [REG_W-1:0] rs2Addr_i,
	output logic [XLEN-1:0]  rs1Data_o,
	output logic [XLEN-1:0]  rs2Data_o,
	input  logic             we_i,
	input  logic [REG_W-1:0] wAddr_i,
	input  logic [XLEN-1:0]  wData_i
);

	// x0 has no storage
	logic [XLEN-1:0] regs [1:NREGS-1];

	// Read with x0 tied low and write-through bypass
	function automatic logic [XLEN-1:0] readPort(input logic [REG_W-1:0] addr);
		logic [XLEN-1:0] val;
		if (addr == '0) begin
			val = '0;
		end else if (we_i && wAddr_i == addr) begin
			val = wData_i;
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	always_comb begin
		rs1Data_o = readPort(rs1Addr_i);
		rs2Data_o = readPort(rs2Addr_i);
	end

	// Writes to x0 are dropped
	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			for (int i = 1; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && wAddr_i != '0) begin
			regs[wAddr_i] <= wData_i;
		end
	end

endmodule

// File: logic/instrDecode.sv
// Decode stage: splits the instruction word, reads operands
// and loads the decode/execute register unless the pipe is stalled
`timescale 1ns/1ps

module instrDecode import riscvPkg::*, pipePkg::*; (
	input  logic             clk_i,
	input  logic             rstN_i,
	input  logic             stall_i,
	input  logic             instrValid_i,
	input  logic [XLEN-1:0]  instr_i,
	input  logic             rfWe_i,
	input  logic [REG_W-1:0] rfWAddr_i,
	input  logic [XLEN-1:0]  rfWData_i,
	output idExT             idEx_o
);

	// Instruction fields
	opcodeE           opcode;
	logic [2:0]       funct3;
	logic             funct7b5;
	logic [REG_W-1:0] rs1;
	logic [REG_W-1:0] rs2;
	logic [REG_W-1:0] rd;

	// Register file read data
	logic [XLEN-1:0] rs1Data;
	logic [XLEN-1:0] rs2Data;

	idExT idExNext;
	idExT idExQ;

	assign opcode   = opcodeE'(instr_i[6:0]);
	assign rd       = instr_i[11:7];
	assign funct3   = instr_i[14:12];
	assign rs1      = instr_i[19:15];
	assign rs2      = instr_i[24:20];
	assign funct7b5 = instr_i[30];

	regFile i_regFile (
		.clk_i     (clk_i),
		.rstN_i    (rstN_i),
		.rs1Addr_i (rs1),
		.rs2Addr_i (rs2),
		.rs1Data_o (rs1Data),
		.rs2Data_o (rs2Data),
		.we_i      (rfWe_i),
		.wAddr_i   (rfWAddr_i),
		.wData_i   (rfWData_i)
	);

	// funct3 to ALU op, SUB only exists in the register form
	function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic alt,
			input logic isReg);
		aluOpE op;
		case (f3)
			F3_ADD:  op = (alt && isReg) ? SUB : ADD;
			F3_SLL:  op = SLL;
			F3_SLT:  op = SLT;
			F3_SLTU: op = SLTU;
			F3_XOR:  op = XOR;
			F3_SR:   op = alt ? SRA : SRL;
			F3_OR:   op = OR;
			default: op = AND;
		endcase
		return op;
	endfunction

	always_comb begin
		idExNext         = '0;
		idExNext.valid   = instrValid_i;
		idExNext.rs1     = rs1;
		idExNext.rs2     = rs2;
		idExNext.rd      = rd;
		idExNext.rs1Data = rs1Data;
		idExNext.rs2Data = rs2Data;
		// I-type immediate by default
		idExNext.imm     = {{(XLEN-12){instr_i[31]}}, instr_i[31:IMM_I_LSB]};
		case (opcode)
			OP: begin
				idExNext.aluOp  = aluFromFunct(funct3, funct7b5, 1'b1);
				idExNext.srcSel = '{aFromReg: 1'b1, bFromReg: 1'b1};
			end
			OP_IMM: begin
				idExNext.aluOp  = aluFromFunct(funct3, funct7b5, 1'b0);
				idExNext.srcSel = '{aFromReg: 1'b1, bFromReg: 1'b0};
			end
			LUI: begin
				// Zero A, upper immediate on B
				idExNext.aluOp  = PASS_B;
				idExNext.srcSel = '{aFromReg: 1'b0, bFromReg: 1'b0};
				idExNext.imm    = {instr_i[31:IMM_U_LSB], {IMM_U_LSB{1'b0}}};
			end
			default: begin
				idExNext.illegal = 1'b1;
			end
		endcase
		// x0 targets and bubbles never write
		idExNext.regWrite = instrValid_i && !idExNext.illegal && (rd != '0);
	end

	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			idExQ.valid    <= 1'b0;
			idExQ.regWrite <= 1'b0;
		end else if (!stall_i) begin
			idExQ <= idExNext;
		end
	end

	assign idEx_o = idExQ;

endmodule

// File: logic/fwdUnit.sv
// Operand forwarding unit for the execute stage
// Picks register file, execute/memory or memory/writeback as source
`timescale 1ns/1ps

module fwdUnit import riscvPkg::*, pipePkg::*; (
	input  fwdCtrlT fwd_i,
	output fwdMuxT  fwd_o
);

	// Nearer producer checked first so the newest value wins
	function automatic fwdSelE pickSrc(input logic fromReg, input logic [REG_W-1:0] rs,
			input fwdCtrlT ctrl);
		fwdSelE sel;
		if (!fromReg || rs == '0) begin
			// Immediate, zero or x0 operand
			sel = NOFWD;
		end else if (ctrl.memRegWrite && rs == ctrl.memRd) begin
			sel = FWD_MEM;
		end else if (ctrl.wbRegWrite && rs == ctrl.wbRd) begin
			sel = FWD_WB;
		end else begin
			// Value read in decode is current
			sel = NOFWD;
		end
		return sel;
	endfunction

	// Operand A compares rs1
	assign fwd_o.fwdA = pickSrc(fwd_i.srcSel.aFromReg, fwd_i.exRs1, fwd_i);

	// Operand B compares rs2
	assign fwd_o.fwdB = pickSrc(fwd_i.srcSel.bFromReg, fwd_i.exRs2, fwd_i);

endmodule

// File: logic/aluExecute.sv
// Execute stage: forwarded operand muxes, ALU
// and the execute/memory register
`timescale 1ns/1ps

module aluExecute import riscvPkg::*, pipePkg::*; (
	input  logic  clk_i,
	input  logic  rstN_i,
	input  logic  stall_i,
	input  idExT  idEx_i,
	input  memWbT wbResult_i,
	output exMemT exMem_o
);

	exMemT   exMemQ;
	exMemT   exMemNext;
	fwdCtrlT fwdCtrl;
	fwdMuxT  fwdMux;

	// Operands after forwarding, then after source select
	logic [XLEN-1:0] rs1Val;
	logic [XLEN-1:0] rs2Val;
	logic [XLEN-1:0] opA;
	logic [XLEN-1:0] opB;
	logic [XLEN-1:0] aluRes;
	logic [4:0]      shamt;

	// Producers only count while their stage holds a valid instruction
	assign fwdCtrl = '{
		exRs1:       idEx_i.rs1,
		exRs2:       idEx_i.rs2,
		srcSel:      idEx_i.srcSel,
		memRd:       exMemQ.rd,
		memRegWrite: exMemQ.valid && exMemQ.regWrite,
		wbRd:        wbResult_i.rd,
		wbRegWrite:  wbResult_i.valid && wbResult_i.regWrite
	};

	fwdUnit i_fwdUnit (
		.fwd_i (fwdCtrl),
		.fwd_o (fwdMux)
	);

	function automatic logic [XLEN-1:0] fwdOperand(input fwdSelE sel,
			input logic [XLEN-1:0] regVal, input logic [XLEN-1:0] memVal,
			input logic [XLEN-1:0] wbVal);
		logic [XLEN-1:0] val;
		case (sel)
			FWD_MEM: val = memVal;
			FWD_WB:  val = wbVal;
			default: val = regVal;
		endcase
		return val;
	endfunction

	assign rs1Val = fwdOperand(fwdMux.fwdA, idEx_i.rs1Data, exMemQ.result, wbResult_i.result);
	assign rs2Val = fwdOperand(fwdMux.fwdB, idEx_i.rs2Data, exMemQ.result, wbResult_i.result);

	// A is zero for LUI, B is the immediate for OP-IMM and LUI
	assign opA   = idEx_i.srcSel.aFromReg ? rs1Val : '0;
	assign opB   = idEx_i.srcSel.bFromReg ? rs2Val : idEx_i.imm;
	assign shamt = opB[4:0];

	always_comb begin
		case (idEx_i.aluOp)
			ADD:     aluRes = opA + opB;
			SUB:     aluRes = opA - opB;
			AND:     aluRes = opA & opB;
			OR:      aluRes = opA | opB;
			XOR:     aluRes = opA ^ opB;
			SLT:     aluRes = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			SLTU:    aluRes = {{(XLEN-1){1'b0}}, opA < opB};
			SLL:     aluRes = opA << shamt;
			SRL:     aluRes = opA >> shamt;
			SRA:     aluRes = $signed(opA) >>> shamt;
			PASS_B:  aluRes = opB;
			default: aluRes = '0;
		endcase
	end

	assign exMemNext = '{
		valid:    idEx_i.valid,
		illegal:  idEx_i.illegal,
		rd:       idEx_i.rd,
		regWrite: idEx_i.regWrite,
		result:   aluRes
	};

	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			exMemQ.valid    <= 1'b0;
			exMemQ.regWrite <= 1'b0;
		end else if (!stall_i) begin
			exMemQ <= exMemNext;
		end
	end

	assign exMem_o = exMemQ;

endmodule

// File: logic/resultStage.sv
// Result stage: memory/writeback register and retire handshake
// Issues the register file write on each retire transfer
`timescale 1ns/1ps

module resultStage import riscvPkg::*, pipePkg::*; (
	input  logic             clk_i,
	input  logic             rstN_i,
	input  logic             retReady_i,
	input  exMemT            exMem_i,
	output memWbT            memWb_o,
	output logic             stall_o,
	output logic             rfWe_o,
	output logic [REG_W-1:0] rfWAddr_o,
	output logic [XLEN-1:0]  rfWData_o,
	output logic             retValid_o,
	output retireT           ret_o
);

	memWbT memWbQ;
	logic  retFire;

	// Held retire blocks the whole pipe
	assign stall_o = memWbQ.valid && !retReady_i;
	assign retFire = memWbQ.valid && retReady_i;

	// No memory access, so the stage is a straight copy
	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			memWbQ.valid    <= 1'b0;
			memWbQ.regWrite <= 1'b0;
		end else if (!stall_o) begin
			memWbQ <= '{
				valid:    exMem_i.valid,
				illegal:  exMem_i.illegal,
				rd:       exMem_i.rd,
				regWrite: exMem_i.regWrite,
				result:   exMem_i.result
			};
		end
	end

	assign memWb_o = memWbQ;

	// Retire payload, stable while held
	assign retValid_o = memWbQ.valid;
	assign ret_o      = '{
		rd:       memWbQ.rd,
		data:     memWbQ.result,
		regWrite: memWbQ.regWrite,
		illegal:  memWbQ.illegal
	};

	// Write lands exactly on the transfer edge
	assign rfWe_o    = retFire && memWbQ.regWrite && (memWbQ.rd != '0);
	assign rfWAddr_o = memWbQ.rd;
	assign rfWData_o = memWbQ.result;

endmodule

// File: logic/rvCore.sv
// Four-stage RV32I subset core, issue and retire on valid/ready ports
// Retire back-pressure freezes all stages at once
`timescale 1ns/1ps

module rvCore import riscvPkg::*, pipePkg::*; (
	input  logic            clk_i,
	input  logic            rstN_i,
	// Issue port
	input  logic            instrValid_i,
	input  logic [XLEN-1:0] instr_i,
	output logic            instrReady_o,
	// Retire port
	output logic            retValid_o,
	output retireT          ret_o,
	input  logic            retReady_i
);

	// Stage registers
	idExT  idEx;
	exMemT exMem;
	memWbT memWb;

	// Global stall from the retire port
	logic stall;

	// Register file write from retire
	logic             rfWe;
	logic [REG_W-1:0] rfWAddr;
	logic [XLEN-1:0]  rfWData;

	assign instrReady_o = !stall;

	instrDecode i_instrDecode (
		.clk_i        (clk_i),
		.rstN_i       (rstN_i),
		.stall_i      (stall),
		.instrValid_i (instrValid_i),
		.instr_i      (instr_i),
		.rfWe_i       (rfWe),
		.rfWAddr_i    (rfWAddr),
		.rfWData_i    (rfWData),
		.idEx_o       (idEx)
	);

	aluExecute i_aluExecute (
		.clk_i      (clk_i),
		.rstN_i     (rstN_i),
		.stall_i    (stall),
		.idEx_i     (idEx),
		.wbResult_i (memWb),
		.exMem_o    (exMem)
	);

	resultStage i_resultStage (
		.clk_i      (clk_i),
		.rstN_i     (rstN_i),
		.retReady_i (retReady_i),
		.exMem_i    (exMem),
		.memWb_o    (memWb),
		.stall_o    (stall),
		.rfWe_o     (rfWe),
		.rfWAddr_o  (rfWAddr),
		.rfWData_o  (rfWData),
		.retValid_o (retValid_o),
		.ret_o      (ret_o)
	);

endmodule

// File: tb/rvCore_assert.sv
// Concurrent checks on the core retire port and reset state
// Bound into every rvCore instance
`timescale 1ns/1ps

module rvCoreAssert import riscvPkg::*, pipePkg::*; (
	input logic   clk_i,
	input logic   rstN_i,
	input logic   retValid_i,
	input retireT ret_i,
	input logic   retReady_i
);

	// Held retire keeps valid and payload until the transfer
	property retHeld;
		@(posedge clk_i) disable iff (!rstN_i)
		retValid_i && !retReady_i |=> retValid_i && $stable(ret_i);
	endproperty

	// x0 is never a write target
	property noX0Write;
		@(posedge clk_i) disable iff (!rstN_i)
		retValid_i |-> !(ret_i.regWrite && ret_i.rd == '0);
	endproperty

	property resetClears;
		@(posedge clk_i) !rstN_i |=> !retValid_i;
	endproperty

	assert property (retHeld) else $error("Retire valid or payload changed while held");
	assert property (noX0Write) else $error("Retire writes register x0");
	assert property (resetClears) else $error("Retire valid high after reset");

endmodule

bind rvCore rvCoreAssert i_rvCoreAssert (
	.clk_i      (clk_i),
	.rstN_i     (rstN_i),
	.retValid_i (retValid_o),
	.ret_i      (ret_o),
	.retReady_i (retReady_i)
);

// File: tb/rvCoreTb.sv
// Directed and random testbench for the four-stage RV32I subset core
// Predicts every retire with a register model and checks them in order
`timescale 1ns/1ps

module rvCoreTb import riscvPkg::*, pipePkg::*; ();

	// Instruction budget per run, sizes the watchdog
	localparam int DIRECTED_INSTR  = 29;
	localparam int RANDOM_INSTR    = 200;
	localparam int WATCHDOG_CYCLES = (DIRECTED_INSTR + RANDOM_INSTR) * 10 + 20;

	logic        clk;
	logic        rstN_i;
	logic        instrValid_i;
	logic [31:0] instr_i;
	logic        instrReady_o;
	logic        retValid_o;
	retireT      ret_o;
	logic        retReady_i;

	// Architectural state as the ISA defines it
	logic [31:0] modelRegs [32];
	retireT      expQ [$];
	retireT      expRet;
	int          errors;
	int          issued;
	int          retired;
	logic [31:0] stimRng;
	logic [31:0] readyRng;
	logic        randomReady;

	rvCore i_rvCore (
		.clk_i        (clk),
		.rstN_i       (rstN_i),
		.instrValid_i (instrValid_i),
		.instr_i      (instr_i),
		.instrReady_o (instrReady_o),
		.retValid_o   (retValid_o),
		.ret_o        (ret_o),
		.retReady_i   (retReady_i)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] makeR(input logic [2:0] f3, input logic alt,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP};
	endfunction

	function automatic logic [31:0] makeI(input logic [2:0] f3, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, OP_IMM};
	endfunction

	function automatic logic [31:0] makeU(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, LUI};
	endfunction

	// Expected retire from ISA semantics, updates the model registers
	function automatic retireT predict(input logic [31:0] instr);
		retireT      r;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic        isReg;
		logic        known;
		a     = modelRegs[instr[19:15]];
		b     = 32'h0;
		isReg = 1'b0;
		known = 1'b1;
		case (instr[6:0])
			OP: begin
				b     = modelRegs[instr[24:20]];
				isReg = 1'b1;
			end
			OP_IMM: b = {{20{instr[31]}}, instr[31:20]};
			LUI: begin
				a = 32'h0;
				b = {instr[31:12], 12'h0};
			end
			default: known = 1'b0;
		endcase
		case (instr[14:12])
			F3_ADD:  res = (isReg && instr[30]) ? a - b : a + b;
			F3_SLL:  res = a << b[4:0];
			F3_SLT:  res = {31'b0, $signed(a) < $signed(b)};
			F3_SLTU: res = {31'b0, a < b};
			F3_XOR:  res = a ^ b;
			F3_SR: begin
				// Arithmetic shift keeps the sign bit of rs1
				if (instr[30]) begin
					res = $signed(a) >>> b[4:0];
				end else begin
					res = a >> b[4:0];
				end
			end
			F3_OR:   res = a | b;
			default: res = a & b;
		endcase
		// LUI ignores funct3, its bits belong to the immediate
		if (instr[6:0] == LUI) begin
			res = b;
		end
		r.rd       = instr[11:7];
		r.data     = res;
		r.illegal  = !known;
		r.regWrite = known && (instr[11:7] != 5'd0);
		if (r.regWrite) begin
			modelRegs[instr[11:7]] = res;
		end
		return r;
	endfunction

	task automatic check(input string name, input logic [31:0] expVal,
			input logic [31:0] actVal);
		if (expVal !== actVal) begin
			$display("ERR time=%0t %s expected=%h actual=%h", $time, name, expVal, actVal);
			errors++;
		end
	endtask

	// Called right after a rising edge, returns right after the transfer edge
	task automatic issue(input logic [31:0] instr);
		logic accepted;
		instrValid_i <= 1'b1;
		instr_i      <= instr;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = instrReady_o;
			@(posedge clk);
		end
		expQ.push_back(predict(instr));
		issued++;
	endtask

	task automatic idle();
		instrValid_i <= 1'b0;
		@(posedge clk);
	endtask

	// Wait for every outstanding retire, watchdog bounds it
	task automatic drain();
		instrValid_i <= 1'b0;
		while (expQ.size() != 0) begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
	endtask

	// Retire monitor, the negedge value is what the next edge transfers
	// Every transfer is counted, expected or not
	always @(negedge clk) begin
		if (rstN_i && retValid_o && retReady_i) begin
			retired++;
			if (expQ.size() == 0) begin
				$display("Retire at %0t with no instruction outstanding", $time);
				errors++;
			end else begin
				expRet = expQ.pop_front();
				check("ret_o.rd", 32'(expRet.rd), 32'(ret_o.rd));
				check("ret_o.illegal", 32'(expRet.illegal), 32'(ret_o.illegal));
				check("ret_o.regWrite", 32'(expRet.regWrite), 32'(ret_o.regWrite));
				// Illegal results carry no defined data
				if (!expRet.illegal) begin
					check("ret_o.data", expRet.data, ret_o.data);
				end
			end
		end
	end

	// Retire back-pressure
	always @(posedge clk) begin
		if (randomReady) begin
			readyRng = xorshift(readyRng);
			retReady_i <= readyRng[7];
		end else begin
			retReady_i <= 1'b1;
		end
	end

	task automatic testReset();
		@(negedge clk);
		check("retValid_o", 32'(1'b0), 32'(retValid_o));
		check("instrReady_o", 32'(1'b1), 32'(instrReady_o));
		@(posedge clk);
	endtask

	// Each consumer reads the previous rd, execute/memory forwarding
	task automatic testBackToBack();
		issue(makeI(F3_ADD, 5'd1, 5'd0, 12'd5));
		issue(makeR(F3_ADD, 1'b0, 5'd2, 5'd1, 5'd1));
		issue(makeI(F3_ADD, 5'd3, 5'd2, -12'sd3));
		issue(makeR(F3_ADD, 1'b0, 5'd4, 5'd3, 5'd2));
		issue(makeR(F3_ADD, 1'b1, 5'd5, 5'd4, 5'd1));
		issue(makeR(F3_SR, 1'b1, 5'd5, 5'd5, 5'd1));
		drain();
	endtask

	task automatic testDistance();
		// Distance two, writeback forwarding
		issue(makeI(F3_ADD, 5'd6, 5'd0, 12'd100));
		issue(makeI(F3_ADD, 5'd7, 5'd0, 12'd7));
		issue(makeR(F3_ADD, 1'b0, 5'd8, 5'd6, 5'd6));
		// Distance three, write-through in the register file
		issue(makeI(F3_ADD, 5'd12, 5'd0, 12'd33));
		issue(makeI(F3_ADD, 5'd13, 5'd0, 12'd1));
		issue(makeI(F3_ADD, 5'd14, 5'd0, 12'd2));
		issue(makeR(F3_XOR, 1'b0, 5'd15, 5'd13, 5'd12));
		// Same rd twice, the later value must win
		issue(makeI(F3_ADD, 5'd16, 5'd0, 12'd10));
		issue(makeI(F3_ADD, 5'd16, 5'd0, 12'd20));
		issue(makeR(F3_ADD, 1'b0, 5'd17, 5'd16, 5'd16));
		issue(makeI(F3_ADD, 5'd18, 5'd0, 12'd3));
		issue(makeI(F3_ADD, 5'd18, 5'd0, 12'd4));
		issue(makeI(F3_OR, 5'd19, 5'd0, 12'd9));
		// SUB gives a different result for each producer of x18
		issue(makeR(F3_ADD, 1'b1, 5'd20, 5'd19, 5'd18));
		drain();
	endtask

	task automatic testX0Lui();
		issue(makeI(F3_ADD, 5'd0, 5'd0, 12'd55));
		issue(makeR(F3_ADD, 1'b0, 5'd24, 5'd0, 5'd0));
		issue(makeU(5'd25, 20'hABCDE));
		issue(makeI(F3_ADD, 5'd26, 5'd25, 12'h123));
		issue(makeU(5'd0, 20'h12345));
		issue(makeR(F3_ADD, 1'b0, 5'd27, 5'd0, 5'd25));
		drain();
	endtask

	task automatic testIllegal();
		// Load and JAL opcodes are outside the subset
		issue({12'd4, 5'd0, 3'b010, 5'd1, 7'b0000011});
		issue({20'h00010, 5'd2, 7'b1101111});
		issue(makeR(F3_ADD, 1'b0, 5'd28, 5'd1, 5'd2));
		drain();
	endtask

	function automatic logic [31:0] randomInstr(input logic [31:0] r);
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm;
		logic [31:0] instr;
		f3  = r[11:9];
		alt = r[12];
		imm = r[31:20];
		// Shift immediates hold a shamt and the arithmetic bit only
		if (f3 == F3_SLL) begin
			imm = {7'b0, imm[4:0]};
		end else if (f3 == F3_SR) begin
			imm = {1'b0, alt, 5'b0, imm[4:0]};
		end
		case (r[14:13])
			2'd0: instr = makeR(f3, alt && (f3 == F3_ADD || f3 == F3_SR),
				{2'b0, r[2:0]}, {2'b0, r[5:3]}, {2'b0, r[8:6]});
			2'd3: instr = makeU({2'b0, r[2:0]}, r[31:12]);
			default: instr = makeI(f3, {2'b0, r[2:0]}, {2'b0, r[5:3]}, imm);
		endcase
		return instr;
	endfunction

	task automatic testRandom();
		int retiredBefore;
		retiredBefore = retired;
		@(negedge clk);
		randomReady = 1'b1;
		@(posedge clk);
		for (int n = 0; n < RANDOM_INSTR; n++) begin
			stimRng = xorshift(stimRng);
			// Occasional bubble on the issue port
			if (stimRng[19:17] == 3'd0) begin
				idle();
			end
			issue(randomInstr(stimRng));
		end
		drain();
		if (retired - retiredBefore != RANDOM_INSTR) begin
			$display("Random stream retired %0d transfers for %0d instructions",
				retired - retiredBefore, RANDOM_INSTR);
			errors++;
		end
		@(negedge clk);
		randomReady = 1'b0;
		@(posedge clk);
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles with %0d retires outstanding",
			WATCHDOG_CYCLES, expQ.size());
		$display("Test failures found");
		$finish;
	end

	initial begin
		rstN_i       = 1'b0;
		instrValid_i = 1'b0;
		instr_i      = 32'h0;
		retReady_i   = 1'b1;
		randomReady  = 1'b0;
		errors       = 0;
		issued       = 0;
		retired      = 0;
		stimRng      = 32'd34;
		// Ready stream runs two steps ahead of the stimulus stream
		readyRng     = xorshift(xorshift(32'd34));
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = 32'h0;
		end
		repeat (5) @(posedge clk);
		rstN_i <= 1'b1;
		testReset();
		testBackToBack();
		testDistance();
		testX0Lui();
		testIllegal();
		testRandom();
		if (expQ.size() != 0 || issued != retired) begin
			$display("%0d instructions issued but %0d retired", issued, retired);
			errors++;
		end
		$display("Errors %0d, issued %0d, retired %0d", errors, issued, retired);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: all.f
logic/riscvPkg.sv
logic/pipePkg.sv
logic/regFile.sv
logic/instrDecode.sv
logic/fwdUnit.sv
logic/aluExecute.sv
logic/resultStage.sv
logic/rvCore.sv
tb/rvCore_assert.sv
tb/rvCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rvCoreTb -f all.f

out=$(./obj_dir/VrvCoreTb)
echo "$out"

if echo "$out" | grep -q 'All tests passed!'; then
	exit 0
else
	exit 1
fi
